// ==== kpt_pkg.sv ====
`default_nettype none

package kpt_pkg;

    localparam int IMG_W   = 8;
    localparam int IMG_H   = 8;
    localparam int NUM_PIX = IMG_W * IMG_H;
    localparam int PIX_W   = 8;

    typedef logic [PIX_W-1:0] pixel_t;
    typedef logic [5:0]       pix_addr_t;   // raster index
    typedef logic [2:0]       coord_t;
    typedef logic [6:0]       kpt_count_t;  // 0..64

    typedef struct packed {
        coord_t row;
        coord_t col;
    } kpt_t;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_BLUR,
        PH_DETECT,
        PH_DONE
    } phase_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [7:0]  adr;
        logic [15:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] dat;
    } wb_rsp_t;

    // register map
    localparam logic [7:0] REG_CTRL   = 8'h00;
    localparam logic [7:0] REG_THRESH = 8'h01;
    localparam logic [7:0] REG_COUNT  = 8'h02;
    localparam logic [7:0] IMG_BASE   = 8'h40;
    localparam logic [7:0] KPT_BASE   = 8'h80;

    localparam int BLUR_PASS_LEN   = NUM_PIX + IMG_W + 1;
    localparam int DETECT_PASS_LEN = NUM_PIX + 1;

endpackage

`default_nettype wire

// ==== pixel_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixel_ram #(
    parameter int DEPTH = 64,
    parameter int WIDTH = 8
) (
    input  logic                                      clk,
    input  logic                                      we,
    input  logic [$clog2(DEPTH > 1 ? DEPTH : 2)-1:0]  addr,
    input  logic [WIDTH-1:0]                          wdata,
    output logic [WIDTH-1:0]                          rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) mem[addr] <= wdata;
        rdata <= mem[addr];  // old data on a same-cycle write
    end

endmodule

`default_nettype wire

// ==== scan_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module scan_counter
    import kpt_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  phase_t     phase,
    output logic [6:0] index,
    output logic       pass_end
);

    logic [6:0] pass_len;

    always_comb begin
        case (phase)
            PH_BLUR:   pass_len = 7'(BLUR_PASS_LEN);
            PH_DETECT: pass_len = 7'(DETECT_PASS_LEN);
            default:   pass_len = '0;  // no pass running
        endcase
    end

    assign pass_end = (pass_len != '0) && (index == pass_len - 7'd1);

    // phase only moves on pass_end or out of idle/done, so this clears at every change
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            index <= '0;
        end else if (pass_end || pass_len == '0) begin
            index <= '0;
        end else begin
            index <= index + 7'd1;
        end
    end

endmodule

`default_nettype wire

// ==== kpt_phase_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module kpt_phase_ctrl
    import kpt_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,
    input  logic   pass_end,
    output phase_t phase
);

    phase_t phase_nxt;

    always_comb begin
        phase_nxt = phase;
        case (phase)
            PH_IDLE, PH_DONE: begin
                if (start) phase_nxt = PH_BLUR;  // rerun keeps the loaded frame
            end
            PH_BLUR: begin
                if (pass_end) phase_nxt = PH_DETECT;
            end
            PH_DETECT: begin
                if (pass_end) phase_nxt = PH_DONE;
            end
            default: phase_nxt = PH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= PH_IDLE;
        end else begin
            phase <= phase_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== kpt_bus_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module kpt_bus_regs
    import kpt_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  wb_req_t    wb_req,
    output wb_rsp_t    wb_rsp,
    input  phase_t     phase,
    input  kpt_count_t kpt_count,
    input  kpt_t       kpt_rdata,
    output logic       start,
    output logic       img_we,
    output pix_addr_t  img_addr,
    output pixel_t     img_wdata,
    output pix_addr_t  kpt_raddr,
    output pixel_t     thresh
);

    logic [1:0]  acc_q;  // 0 idle, 1 sampled, 2 ack on next edge
    logic        ack_q;
    logic [15:0] rdat;
    logic [15:0] rdat_q;
    logic        busy;
    logic        done;
    logic        fire;
    logic        wr;
    logic        hit_img;
    logic        hit_kpt;

    assign busy    = (phase == PH_BLUR) || (phase == PH_DETECT);
    assign done    = (phase == PH_DONE);
    assign fire    = (acc_q == 2'd2);
    assign wr      = fire && wb_req.we;
    assign hit_img = (wb_req.adr[7:6] == IMG_BASE[7:6]);
    assign hit_kpt = (wb_req.adr[7:6] == KPT_BASE[7:6]);

    assign start     = wr && (wb_req.adr == REG_CTRL) && wb_req.dat[0] && !busy;
    assign img_we    = wr && hit_img && !busy;  // dropped while busy
    assign img_addr  = wb_req.adr[5:0];
    assign img_wdata = wb_req.dat[PIX_W-1:0];
    assign kpt_raddr = wb_req.adr[5:0];   // ram output lands before ack

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_q  <= 2'd0;
            ack_q  <= 1'b0;
            thresh <= '0;
        end else begin
            ack_q <= fire;
            case (acc_q)
                2'd0: begin
                    if (wb_req.cyc && wb_req.stb && !ack_q) acc_q <= 2'd1;
                end
                2'd1:    acc_q <= 2'd2;
                default: acc_q <= 2'd0;
            endcase
            if (wr && wb_req.adr == REG_THRESH) thresh <= wb_req.dat[PIX_W-1:0];
        end
    end

    always_comb begin
        rdat = '0;
        case (wb_req.adr)
            REG_CTRL:   rdat = {14'd0, done, busy};
            REG_THRESH: rdat = {8'd0, thresh};
            REG_COUNT:  rdat = {9'd0, kpt_count};
            default: begin
                if (hit_kpt) rdat = {10'd0, kpt_rdata};
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (fire) rdat_q <= rdat;
    end

    assign wb_rsp = '{ack: ack_q, dat: rdat_q};

endmodule

`default_nettype wire

// ==== gauss_window.sv ====
`timescale 1ns/1ns
`default_nettype none

module gauss_window
    import kpt_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  phase_t     phase,
    input  logic [6:0] index,
    input  pixel_t     pixel_in,
    output logic       blur_we,
    output pix_addr_t  blur_addr,
    output pixel_t     blur_out
);

    logic        in_vld_q;
    logic [6:0]  in_idx_q;  // raster index of pixel_in
    logic [6:0]  ctr_idx;
    coord_t      ctr_row;
    coord_t      ctr_col;
    pixel_t      line1 [IMG_W];
    pixel_t      line2 [IMG_W];
    pixel_t      top_q [2];
    pixel_t      mid_q [2];
    pixel_t      bot_q [2];
    pixel_t      tap   [3][3];
    logic [11:0] sum;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_vld_q <= 1'b0;
        end else begin
            in_vld_q <= (phase == PH_BLUR);  // ram data trails the address by one
        end
    end

    always_ff @(posedge clk) begin
        in_idx_q <= index;
        if (in_vld_q) begin
            line1[0] <= pixel_in;
            line2[0] <= line1[IMG_W-1];
            for (int i = 1; i < IMG_W; i++) begin
                line1[i] <= line1[i-1];
                line2[i] <= line2[i-1];
            end
            bot_q[1] <= pixel_in;
            bot_q[0] <= bot_q[1];
            mid_q[1] <= line1[IMG_W-1];
            mid_q[0] <= mid_q[1];
            top_q[1] <= line2[IMG_W-1];
            top_q[0] <= top_q[1];
        end
    end

    // centre sits IMG_W+1 pixels behind the newest one
    assign ctr_idx = in_idx_q - 7'(IMG_W + 1);
    assign ctr_row = ctr_idx[5:3];
    assign ctr_col = ctr_idx[2:0];

    always_comb begin
        tap[0] = '{top_q[0], top_q[1], line2[IMG_W-1]};
        tap[1] = '{mid_q[0], mid_q[1], line1[IMG_W-1]};
        tap[2] = '{bot_q[0], bot_q[1], pixel_in};
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                if ((r == 0 && ctr_row == '0) || (r == 2 && ctr_row == coord_t'(IMG_H - 1)) ||
                    (c == 0 && ctr_col == '0) || (c == 2 && ctr_col == coord_t'(IMG_W - 1))) begin
                    tap[r][c] = '0;  // outside the frame
                end
            end
        end
    end

    always_comb begin
        sum = '0;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                sum = sum + (12'(tap[r][c]) << (int'(r == 1) + int'(c == 1)));
            end
        end
    end

    assign blur_we   = in_vld_q && (in_idx_q >= 7'(IMG_W + 1));
    assign blur_addr = ctr_idx[5:0];
    assign blur_out  = sum[11:4];  // divide by 16, truncated

endmodule

`default_nettype wire

// ==== dog_detect.sv ====
`timescale 1ns/1ns
`default_nettype none

module dog_detect
    import kpt_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  phase_t     phase,
    input  logic [6:0] index,
    input  pixel_t     orig,
    input  pixel_t     blur,
    input  pixel_t     thresh,
    output logic       kpt_we,
    output pix_addr_t  kpt_waddr,
    output kpt_t       kpt_wdata,
    output kpt_count_t kpt_count
);

    logic      vld_q;
    pix_addr_t pix_q;
    pixel_t    diff;
    logic      hit;

    // step 0 reads nothing, step n reads pixel n-1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= (phase == PH_DETECT) && (index != '0);
        end
    end

    always_ff @(posedge clk) begin
        pix_q <= pix_addr_t'(index - 7'd1);
    end

    assign diff = (orig > blur) ? orig - blur : blur - orig;
    assign hit  = vld_q && (diff >= thresh);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kpt_count <= '0;
        end else if (phase == PH_DETECT && index == '0) begin
            kpt_count <= '0;
        end else if (hit) begin
            kpt_count <= kpt_count + 7'd1;
        end
    end

    assign kpt_we    = hit;
    assign kpt_waddr = kpt_count[5:0];  // next free slot
    assign kpt_wdata = '{row: pix_q[5:3], col: pix_q[2:0]};

endmodule

`default_nettype wire

// ==== kpt_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module kpt_core
    import kpt_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    phase_t     phase;
    logic       start;
    logic       pass_end;
    logic [6:0] index;
    logic       img_we;
    pix_addr_t  bus_img_addr;
    pixel_t     img_wdata;
    pixel_t     img_rdata;
    pix_addr_t  img_ram_addr;
    pix_addr_t  scan_addr;
    pixel_t     thresh;
    logic       blur_we;
    pix_addr_t  blur_waddr;
    pix_addr_t  blur_ram_addr;
    pixel_t     blur_wdata;
    pixel_t     blur_rdata;
    logic       kpt_we;
    pix_addr_t  kpt_waddr;
    pix_addr_t  kpt_raddr;
    pix_addr_t  kpt_ram_addr;
    kpt_t       kpt_wdata;
    kpt_t       kpt_rdata;
    kpt_count_t kpt_count;

    // detect step 0 leaves the blur port to the last window write
    assign scan_addr     = (phase == PH_DETECT) ? pix_addr_t'(index - 7'd1) : index[5:0];
    assign img_ram_addr  = (phase == PH_IDLE || phase == PH_DONE) ? bus_img_addr : scan_addr;
    assign blur_ram_addr = blur_we ? blur_waddr : scan_addr;
    assign kpt_ram_addr  = (phase == PH_DETECT || kpt_we) ? kpt_waddr : kpt_raddr;

    kpt_bus_regs i_bus_regs (
        .clk, .rst_n, .wb_req, .wb_rsp, .phase, .kpt_count, .kpt_rdata, .start, .img_we,
        .img_addr (bus_img_addr),
        .img_wdata, .kpt_raddr, .thresh
    );

    kpt_phase_ctrl i_phase_ctrl (
        .clk, .rst_n, .start, .pass_end, .phase
    );

    scan_counter i_scan (
        .clk, .rst_n, .phase, .index, .pass_end
    );

    pixel_ram #(.DEPTH(NUM_PIX), .WIDTH(PIX_W)) i_img_ram (
        .clk,
        .we    (img_we),
        .addr  (img_ram_addr),
        .wdata (img_wdata),
        .rdata (img_rdata)
    );

    pixel_ram #(.DEPTH(NUM_PIX), .WIDTH(PIX_W)) i_blur_ram (
        .clk,
        .we    (blur_we),
        .addr  (blur_ram_addr),
        .wdata (blur_wdata),
        .rdata (blur_rdata)
    );

    pixel_ram #(.DEPTH(NUM_PIX), .WIDTH($bits(kpt_t))) i_kpt_ram (
        .clk,
        .we    (kpt_we),
        .addr  (kpt_ram_addr),
        .wdata (kpt_wdata),
        .rdata (kpt_rdata)
    );

    gauss_window i_gauss (
        .clk, .rst_n, .phase, .index,
        .pixel_in  (img_rdata),
        .blur_we,
        .blur_addr (blur_waddr),
        .blur_out  (blur_wdata)
    );

    dog_detect i_detect (
        .clk, .rst_n, .phase, .index,
        .orig (img_rdata),
        .blur (blur_rdata),
        .thresh, .kpt_we, .kpt_waddr, .kpt_wdata, .kpt_count
    );

endmodule

`default_nettype wire

// ==== tb_kpt_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_kpt_core
    import kpt_pkg::*;
();

    localparam int CLK_PERIOD  = 10;
    localparam int ACK_LIMIT   = 16;
    localparam int POLL_LIMIT  = BLUR_PASS_LEN + DETECT_PASS_LEN;
    localparam int NUM_RUNS    = 4;
    localparam int BUS_ACCESSES = 2 + 3 * (NUM_PIX + 1) + NUM_RUNS * (POLL_LIMIT + NUM_PIX + 3) + 3;
    localparam int WATCHDOG_CYCLES = 4 * 2 * (BLUR_PASS_LEN + DETECT_PASS_LEN) + BUS_ACCESSES * 10;
    localparam int SPOT_PIX    = 3 * IMG_W + 4;  // bright spot of frame 1

    logic       clk;
    logic       rst_n;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    logic [7:0] golden [256];
    int         errors;
    int         tests_run;
    int         tests_failed;

    kpt_core i_dut (
        .clk, .rst_n, .wb_req, .wb_rsp
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    // called on a falling edge, returns on a falling edge
    task automatic bus_access(input logic we, input logic [7:0] adr, input logic [15:0] wdat,
                              output logic [15:0] rdat);
        int waited;
        waited     = 0;
        rdat       = '0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        @(negedge clk);
        while (!wb_rsp.ack && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (wb_rsp.ack) begin
            rdat = wb_rsp.dat;
        end else begin
            $display("no ack from the DUT for the access to address %02h", adr);
            errors++;
        end
        wb_req = '0;
    endtask

    task automatic bus_write(input logic [7:0] adr, input logic [15:0] dat);
        logic [15:0] ignored;
        bus_access(1'b1, adr, dat, ignored);
    endtask

    task automatic bus_read(input logic [7:0] adr, output logic [15:0] dat);
        bus_access(1'b0, adr, 16'h0000, dat);
    endtask

    task automatic check_status(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %04h, expected %04h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input kpt_count_t got, input kpt_count_t exp);
        if (got !== exp) begin
            $display("FAILED kpt_count: got %02h, expected %02h", got, exp);
            errors++;
        end
    endtask

    task automatic check_kpt(input int slot, input kpt_t got, input kpt_t exp);
        if (got !== exp) begin
            $display("FAILED kpt_rdata[%0d]: got %02h, expected %02h", slot, got, exp);
            errors++;
        end
    endtask

    task automatic load_frame(input int base);
        bus_write(REG_THRESH, {8'd0, golden[base]});
        for (int p = 0; p < NUM_PIX; p++) begin
            bus_write(IMG_BASE + 8'(p), {8'd0, golden[base + 1 + p]});
        end
    endtask

    task automatic wait_done();
        logic [15:0] rdat;
        int          polls;
        polls = 0;
        rdat  = '0;
        while (rdat[1] !== 1'b1 && polls < POLL_LIMIT) begin
            bus_read(REG_CTRL, rdat);
            polls++;
        end
        if (rdat[1] !== 1'b1) begin
            $display("run did not reach done after %0d status polls", polls);
            errors++;
        end
    endtask

    task automatic check_result(input int base);
        logic [15:0] rdat;
        kpt_count_t  exp_cnt;
        exp_cnt = kpt_count_t'(golden[base + 1 + NUM_PIX]);
        bus_read(REG_COUNT, rdat);
        check_count(kpt_count_t'(rdat[6:0]), exp_cnt);
        for (int i = 0; i < int'(exp_cnt); i++) begin
            bus_read(KPT_BASE + 8'(i), rdat);
            check_kpt(i, kpt_t'(rdat[5:0]), kpt_t'(golden[base + 2 + NUM_PIX + i][5:0]));
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors > errors_before) begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    initial begin
        logic [15:0] rdat;
        int          mark;
        int          f2_base;
        wb_req       = '0;
        rst_n        = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        $readmemh("kpt_golden.txt", golden);
        f2_base = NUM_PIX + 2 + int'(golden[NUM_PIX + 1]);
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        mark = errors;
        bus_read(REG_CTRL, rdat);
        check_status("REG_CTRL", rdat, 16'h0000);
        bus_read(REG_COUNT, rdat);
        check_status("REG_COUNT", rdat, 16'h0000);
        finish_test("reset state", mark);

        mark = errors;
        load_frame(0);
        bus_write(REG_CTRL, 16'h0001);
        wait_done();
        check_result(0);
        finish_test("frame 1 keypoints", mark);

        mark = errors;
        load_frame(f2_base);
        bus_write(REG_CTRL, 16'h0001);
        wait_done();
        check_result(f2_base);
        finish_test("frame 2 border keypoints", mark);

        mark = errors;
        load_frame(0);
        bus_write(REG_CTRL, 16'h0001);
        bus_write(REG_CTRL, 16'h0001);  // second start mid-run
        bus_write(IMG_BASE + 8'(SPOT_PIX), {8'd0, ~golden[1 + SPOT_PIX]});
        bus_read(REG_CTRL, rdat);
        check_status("REG_CTRL", rdat, 16'h0001);
        wait_done();
        check_result(0);
        finish_test("accesses while busy", mark);

        mark = errors;
        bus_read(REG_CTRL, rdat);
        check_status("REG_CTRL", rdat, 16'h0002);
        bus_write(REG_CTRL, 16'h0001);
        bus_read(REG_CTRL, rdat);
        check_status("REG_CTRL", rdat, 16'h0001);  // rerun really started
        wait_done();
        check_result(0);
        finish_test("rerun of loaded frame", mark);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== kpt_golden.txt ====
// per frame: threshold, 8 pixel rows of 8, keypoint count, then keypoints as row*8+col
// all values hex, keypoints in raster order
// frame 1 gradient along the columns, bright spot at row 3 col 4
14
10 18 20 28 30 38 40 48
10 18 20 28 30 38 40 48
10 18 20 28 30 38 40 48
10 18 20 28 F8 38 40 48
10 18 20 28 30 38 40 48
10 18 20 28 30 38 40 48
10 18 20 28 30 38 40 48
10 18 20 28 30 38 40 48
0D
07 0F 14 17 1B 1C 1D 1F 24 27 2F 37 3F
// frame 2 flat, bright pixels on the top, left and bottom right border
18
40 40 40 C0 40 40 40 40
40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40
A0 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 E0
06
00 03 07 20 38 3F

// ==== kpt_core.f ====
kpt_pkg.sv
pixel_ram.sv
scan_counter.sv
kpt_phase_ctrl.sv
kpt_bus_regs.sv
gauss_window.sv
dog_detect.sv
kpt_core.sv
tb_kpt_core.sv
